// File: list.f
logic/rv_pkg.sv
logic/rv_imm_decode.sv
logic/rv_trap_csr.sv
logic/rv_core.sv
logic/board_bus.sv
logic/dual_port_ram.sv
logic/cpu_on_board.sv
testbench/tb_cpu_on_board.sv

// File: prog.mem
// One instruction per line in hex, bytes swapped into big-endian order
// The @40 line puts the trap handler at word 0x40, byte address 0x100
37250000 // 00 lui   x10, 0x2         char port 0x2000
93001004 // 04 addi  x1, x0, 0x41
97010000 // 08 auipc x3, 0            x3 = 0x08
23301500 // 0c sd    x1, 0(x10)       byte 0x41
1302f0ff // 10 addi  x4, x0, -1
93021000 // 14 addi  x5, x0, 1
33235200 // 18 slt   x6, x4, x5
23306500 // 1c sd    x6, 0(x10)       byte 0x01
23303500 // 20 sd    x3, 0(x10)       byte 0x08
93030000 // 24 addi  x7, x0, 0        counter
13043000 // 28 addi  x8, x0, 3        limit
93831300 // 2c addi  x7, x7, 1        loop top
23307500 // 30 sd    x7, 0(x10)
b3a48300 // 34 slt   x9, x7, x8
e38a54fe // 38 beq   x9, x5, -12      back to 0x2c
9305a005 // 3c addi  x11, x0, 0x5a
13060040 // 40 addi  x12, x0, 0x400
13060640 // 44 addi  x12, x12, 0x400  x12 = 0x800, RAM word 0x200
2330b600 // 48 sd    x11, 0(x12)
83360600 // 4c ld    x13, 0(x12)
2330d500 // 50 sd    x13, 0(x10)      byte 0x5a
ef00c000 // 54 jal   x1, +12          call 0x60
6f000000 // 58 jal   x0, 0            idle loop
13000000 // 5c nop
1307a004 // 60 addi  x14, x0, 0x4a    subroutine
2330e500 // 64 sd    x14, 0(x10)      byte 0x4a
67800000 // 68 jalr  x0, 0(x1)        back to 0x58
@40
9307e00e // 100 addi x15, x0, 0xee    handler
2330f500 // 104 sd   x15, 0(x10)      byte 0xee
73002030 // 108 mret

// File: testbench/tb_cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_on_board;
    localparam int reset_cycles   = 16;
    localparam int program_cycles = 300;  // Reset release to idle loop, rough
    localparam int max_irq_delay  = 60;
    localparam int handler_cycles = 24;
    localparam int quiet_cycles   = 100;  // Window after the handler byte
    // 4000 cycles, wide margin over the sum
    localparam int cycle_limit    = 8 * (reset_cycles + program_cycles + max_irq_delay
                                         + handler_cycles + quiet_cycles);
    localparam logic [63:0] idle_pc = 64'h0000_0000_0000_0058;  // Address of the idle jal

    logic       CLOCK_50;
    logic       KEY0;
    logic       irq;
    wire  [7:0] char_data;
    wire        char_valid;
    wire        irq_ack;
    wire  [5:0] pc_leds;

    logic [7:0] byte_q [$];           // Every byte seen on the char port
    logic [7:0] expected [0:8];
    int         test_errors [1:5];
    int         error_count;
    int         cycle_count;
    int         ack_count;
    int         delay;
    int         passed;
    int         idx;
    integer     seed;
    logic       early_window;         // Reset plus the first 3 cycles
    logic       idle_before_irq;
    logic       idle_after_mret;

    cpu_on_board dut0 (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .irq        (irq),
        .char_data  (char_data),
        .char_valid (char_valid),
        .irq_ack    (irq_ack),
        .pc_leds    (pc_leds)
    );

    task automatic record_error(input int test_id);
        test_errors[test_id]++;
        error_count++;
    endtask

    task automatic wait_for_bytes(input int count);
        while (byte_q.size() < count) begin
            @(posedge CLOCK_50);      // Watchdog ends a stuck wait
        end
    endtask

    // pc / 4 on the LEDs shows the idle jal being fetched
    task automatic wait_for_idle();
        @(negedge CLOCK_50);
        while (pc_leds !== idle_pc[7:2]) begin
            @(negedge CLOCK_50);
        end
    endtask

    task automatic check_byte(input int index, input int test_id);
        assert (byte_q[index] == expected[index]) else begin
            $display("ERROR: char_data byte %0d expected 0x%02h got 0x%02h",
                     index, expected[index], byte_q[index]);
            record_error(test_id);
        end
    endtask

    task automatic check_count(input string name, input int actual, input int want,
                               input int test_id);
        assert (actual == want) else begin
            $display("ERROR: %s expected 0x%0h got 0x%0h", name, want, actual);
            record_error(test_id);
        end
    endtask

    // Idle loop keeps pc on its own word or the two prefetched after it
    task automatic check_idle_pc(input int test_id);
        logic [5:0] low;
        logic [5:0] high;
        low  = idle_pc[7:2];
        high = idle_pc[7:2] + 6'd2;
        assert (pc_leds >= low && pc_leds <= high) else begin
            $display("ERROR: pc_leds expected 0x%0h to 0x%0h got 0x%0h",
                     low, high, pc_leds);
            record_error(test_id);
        end
    endtask

    task automatic finish_test(input int test_id, input string name);
        $display("[test %0d] %-24s %s (%0d errors)", test_id, name,
                 (test_errors[test_id] == 0) ? "PASS" : "FAIL", test_errors[test_id]);
    endtask

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;     // 100 ns period
    end

    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d bytes seen", cycle_count, byte_q.size());
            $display("Test failed");
            $finish;
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge CLOCK_50) begin
        if (KEY0 === 1'b1 && char_valid === 1'b1) begin
            byte_q.push_back(char_data);
        end
        if (KEY0 === 1'b1 && irq_ack === 1'b1) begin
            ack_count++;
        end
    end

    assert property (@(posedge CLOCK_50) early_window |-> !char_valid)
        else begin
            $display("ERROR: char_valid expected 0x0 got 0x1 in the reset window");
            record_error(1);
        end

    assert property (@(posedge CLOCK_50) early_window |-> !irq_ack)
        else begin
            $display("ERROR: irq_ack expected 0x0 got 0x1 in the reset window");
            record_error(1);
        end

    // Nothing printed while spinning in the idle loop
    assert property (@(posedge CLOCK_50) idle_before_irq |-> !char_valid)
        else begin
            $display("ERROR: char_valid expected 0x0 got 0x1 before irq");
            record_error(3);
        end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) irq_ack |=> !irq_ack)
        else begin
            $display("ERROR: irq_ack expected 0x0 got 0x1 on the cycle after the ack");
            record_error(4);
        end

    assert property (@(posedge CLOCK_50) idle_after_mret |-> !char_valid)
        else begin
            $display("ERROR: char_valid expected 0x0 got 0x1 after mret");
            record_error(5);
        end

    assert property (@(posedge CLOCK_50) idle_after_mret |-> !irq_ack)
        else begin
            $display("ERROR: irq_ack expected 0x0 got 0x1 after mret");
            record_error(5);
        end

    initial begin
        seed            = 15434;
        KEY0            = 1'b0;
        irq             = 1'b0;
        early_window    = 1'b1;
        idle_before_irq = 1'b0;
        idle_after_mret = 1'b0;
        error_count     = 0;
        cycle_count     = 0;
        ack_count       = 0;
        foreach (test_errors[i]) begin
            test_errors[i] = 0;
        end
        expected[0] = 8'h41;      // lui/addi constant
        expected[1] = 8'h01;      // slt, -1 < 1
        expected[2] = 8'h08;      // auipc 0 at pc 0x08
        expected[3] = 8'h01;      // Loop counter
        expected[4] = 8'h02;
        expected[5] = 8'h03;
        expected[6] = 8'h5A;      // sd then ld of RAM word 0x200
        expected[7] = 8'h4A;      // From the jal subroutine
        expected[8] = 8'hEE;      // Trap handler

        repeat (reset_cycles) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        repeat (3) @(posedge CLOCK_50);
        early_window <= 1'b0;
        @(negedge CLOCK_50);
        finish_test(1, "reset quiet");

        wait_for_bytes(7);
        for (idx = 0; idx < 7; idx++) begin
            check_byte(idx, 2);
        end
        finish_test(2, "arithmetic, loop, ld/sd");

        wait_for_bytes(8);
        check_byte(7, 3);
        @(posedge CLOCK_50);
        idle_before_irq <= 1'b1;
        // Byte 8 lands a few cycles before jalr reaches the idle loop
        wait_for_idle();
        delay = 20 + int'($unsigned($random(seed)) % 41);
        repeat (delay) @(posedge CLOCK_50);
        check_count("char_valid count", byte_q.size(), 8, 3);
        irq             <= 1'b1;  // One-cycle request
        idle_before_irq <= 1'b0;
        @(posedge CLOCK_50);
        irq <= 1'b0;
        finish_test(3, "jalr back to idle");

        wait_for_bytes(9);
        check_byte(8, 4);
        check_count("irq_ack pulses", ack_count, 1, 4);
        finish_test(4, "interrupt handler");

        @(posedge CLOCK_50);
        idle_after_mret <= 1'b1;
        repeat (quiet_cycles) @(posedge CLOCK_50);
        idle_after_mret <= 1'b0;
        @(negedge CLOCK_50);
        check_count("char_valid count", byte_q.size(), 9, 5);
        check_count("irq_ack pulses", ack_count, 1, 5);   // Request not taken twice
        check_idle_pc(5);
        finish_test(5, "mret back to idle");

        passed = 0;
        foreach (test_errors[i]) begin
            if (test_errors[i] == 0) begin
                passed++;
            end
        end
        $display("Summary: %0d of 5 tests passed, %0d errors, %0d cycles",
                 passed, error_count, cycle_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: logic/cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board (
    input  wire       CLOCK_50,
    input  wire       KEY0,       // Reset button, low active
    input  wire       irq,        // External interrupt request
    output wire [7:0] char_data,
    output wire       char_valid,
    output wire       irq_ack,
    output wire [5:0] pc_leds     // pc / 4
);
    // Fetch path, core to RAM port A
    wire [rv_pkg::ram_addr_bits-1:0] fetch_addr;
    wire [31:0]                      fetch_word;

    // Core bus
    wire [rv_pkg::xlen-1:0] bus_address;
    wire [rv_pkg::xlen-1:0] bus_write_data;
    wire                    bus_write_enable;
    wire                    bus_read_enable;
    wire [rv_pkg::xlen-1:0] bus_read_data;

    // Bus to RAM port B
    wire [rv_pkg::ram_addr_bits-1:0] ram_addr;
    wire [31:0]                      ram_wdata;
    wire                             ram_we;
    wire                             ram_re;
    wire [31:0]                      ram_rdata;

    wire irq_pending;   // Latched request

    rv_core u_core (.*);

    board_bus u_bus (.*);

    dual_port_ram #(
        .depth (rv_pkg::ram_words),
        .width (32)
    ) u_ram (.*);
endmodule

`default_nettype wire

// File: logic/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int depth = 1024,
    parameter int width = 32
) (
    input  wire                      CLOCK_50,
    input  wire  [$clog2(depth)-1:0] fetch_addr,  // Port A, instructions
    output logic [width-1:0]         fetch_word,
    input  wire  [$clog2(depth)-1:0] ram_addr,    // Port B, data
    input  wire  [width-1:0]         ram_wdata,
    input  wire                      ram_we,
    input  wire                      ram_re,
    output logic [width-1:0]         ram_rdata
);
    logic [width-1:0] mem [0:depth-1];

    initial begin
        $readmemh("prog.mem", mem);
    end

    // Fetch reads every cycle
    always_ff @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_addr];
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
        if (ram_re) begin
            ram_rdata <= mem[ram_addr];   // Holds until the next read
        end
    end
endmodule

`default_nettype wire

// File: logic/board_bus.sv
`timescale 1ns/1ps
`default_nettype none

module board_bus (
    input  wire                              CLOCK_50,
    input  wire                              KEY0,
    input  wire  [rv_pkg::xlen-1:0]          bus_address,
    input  wire  [rv_pkg::xlen-1:0]          bus_write_data,
    input  wire                              bus_write_enable,
    input  wire                              bus_read_enable,
    output logic [rv_pkg::xlen-1:0]          bus_read_data,
    output logic [rv_pkg::ram_addr_bits-1:0] ram_addr,
    output logic [31:0]                      ram_wdata,
    output logic                             ram_we,
    output logic                             ram_re,
    input  wire  [31:0]                      ram_rdata,
    input  wire                              irq,
    input  wire                              irq_ack,
    output logic                             irq_pending,
    output logic [7:0]                       char_data,
    output logic                             char_valid
);
    logic ram_sel;
    logic char_sel;
    logic char_wr;
    logic char_wr_q;    // Write strobe one cycle ago
    logic rd_ram_q;     // Last read went to RAM

    assign ram_sel  = (bus_address >= rv_pkg::ram_base) &&
                      (bus_address < rv_pkg::ram_base + 4 * rv_pkg::ram_words);
    assign char_sel = (bus_address == rv_pkg::char_addr);

    // RAM is 32 bits wide, upper half of sd dropped
    assign ram_addr  = bus_address[rv_pkg::ram_addr_bits+1:2];
    assign ram_wdata = bus_write_data[31:0];
    assign ram_we    = bus_write_enable && ram_sel;
    assign ram_re    = bus_read_enable && ram_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_ram_q <= 1'b0;
        end else if (bus_read_enable) begin
            rd_ram_q <= ram_sel;
        end
    end

    // Word arrives with the select, zero-extended
    assign bus_read_data = rd_ram_q ? {32'd0, ram_rdata} : '0;

    assign char_wr    = bus_write_enable && char_sel;
    assign char_valid = char_wr && !char_wr_q;    // First cycle of the write only
    assign char_data  = bus_write_data[7:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            char_wr_q   <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            char_wr_q <= char_wr;
            if (irq_ack) begin
                irq_pending <= 1'b0;   // Serviced
            end else if (irq) begin
                irq_pending <= 1'b1;   // Held until the core answers
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) char_valid |=> !char_valid);
endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                              CLOCK_50,
    input  wire                              KEY0,
    output logic [rv_pkg::ram_addr_bits-1:0] fetch_addr,
    input  wire  [31:0]                      fetch_word,
    input  wire                              irq_pending,
    output logic                             irq_ack,
    output logic [rv_pkg::xlen-1:0]          bus_address,
    output logic [rv_pkg::xlen-1:0]          bus_write_data,
    output logic                             bus_write_enable,
    output logic                             bus_read_enable,
    input  wire  [rv_pkg::xlen-1:0]          bus_read_data,
    output logic [5:0]                       pc_leds
);
    logic [rv_pkg::xlen-1:0] pc;
    logic [31:0]             ir;
    logic [1:0]              bubble;   // Wrong-path slots still to drop
    logic                    ld_step;  // ld waiting for its data
    logic [rv_pkg::xlen-1:0] rf [0:31];

    logic [4:0]                     rd, rs1, rs2;
    logic signed [rv_pkg::xlen-1:0] imm_u, imm_i, imm_s, imm_b, imm_j;
    logic                           mie;
    logic [rv_pkg::xlen-1:0]        mepc;

    logic [rv_pkg::xlen-1:0] ir_pc, src1, src2;
    logic [rv_pkg::xlen-1:0] pc_n, addr_n, wb_data;
    logic [1:0]              bubble_n;
    logic                    ld_step_n, re_n, we_n, hold_ir, wb_en;
    logic                    take_trap, do_mret;

    rv_imm_decode u_dec (.*);

    rv_trap_csr u_csr (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .take_trap (take_trap),
        .do_mret   (do_mret),
        .trap_pc   (ir_pc),
        .mie       (mie),
        .mepc      (mepc)
    );

    assign fetch_addr = pc[rv_pkg::ram_addr_bits+1:2];
    assign pc_leds    = pc[7:2];
    assign ir_pc      = pc - 64'd8;   // RAM and ir sit two words behind pc
    assign src1       = rf[rs1];
    assign src2       = rf[rs2];
    // Never on a squashed slot or between the two ld steps
    assign take_trap  = irq_pending && mie && bubble == 2'd0 && !ld_step;

    always_comb begin
        pc_n      = pc + 64'd4;
        bubble_n  = (bubble != 2'd0) ? bubble - 2'd1 : 2'd0;
        ld_step_n = ld_step;
        hold_ir   = 1'b0;
        re_n      = 1'b0;
        we_n      = 1'b0;
        addr_n    = src1 + imm_i;     // ld address
        wb_en     = 1'b0;
        wb_data   = ir_pc + 64'd4;    // Link for jal and jalr
        do_mret   = 1'b0;
        if (take_trap) begin
            pc_n     = rv_pkg::trap_vector;
            bubble_n = 2'd2;
        end else if (bubble != 2'd0) begin
            hold_ir = ld_step;        // Keep ld in ir for step 1
        end else begin
            casez ({ir[14:12], ir[6:0]})
                {3'b???, rv_pkg::op_lui}: begin
                    wb_en   = 1'b1;
                    wb_data = imm_u;
                end
                {3'b???, rv_pkg::op_auipc}: begin
                    wb_en   = 1'b1;
                    wb_data = ir_pc + imm_u;
                end
                {rv_pkg::funct3_beq_addi, rv_pkg::op_imm}: begin    // addi
                    wb_en   = 1'b1;
                    wb_data = src1 + imm_i;
                end
                {3'b010, rv_pkg::op_reg}: begin                     // slt
                    wb_en   = 1'b1;
                    wb_data = {63'd0, $signed(src1) < $signed(src2)};
                end
                {rv_pkg::funct3_beq_addi, rv_pkg::op_branch}: begin // beq
                    if (src1 == src2) begin
                        pc_n     = ir_pc + imm_b;
                        bubble_n = 2'd2;
                    end
                end
                {3'b???, rv_pkg::op_jal}: begin
                    wb_en    = 1'b1;
                    pc_n     = ir_pc + imm_j;
                    bubble_n = 2'd2;
                end
                {3'b???, rv_pkg::op_jalr}: begin
                    wb_en    = 1'b1;
                    pc_n     = (src1 + imm_i) & ~64'd1;
                    bubble_n = 2'd2;
                end
                {rv_pkg::funct3_ld_sd, rv_pkg::op_load}: begin
                    if (!ld_step) begin
                        // Step 0 issues the read and refetches ld+4
                        re_n      = 1'b1;
                        ld_step_n = 1'b1;
                        hold_ir   = 1'b1;
                        bubble_n  = 2'd1;
                        pc_n      = pc - 64'd4;
                    end else begin
                        wb_en     = 1'b1;     // Step 1, data on the bus
                        wb_data   = bus_read_data;
                        ld_step_n = 1'b0;
                    end
                end
                {rv_pkg::funct3_ld_sd, rv_pkg::op_store}: begin
                    we_n     = 1'b1;
                    addr_n   = src1 + imm_s;
                    pc_n     = pc - 64'd4;    // Drain, resume at sd+4
                    bubble_n = 2'd2;
                end
                {3'b???, rv_pkg::op_system}: begin
                    if (ir == rv_pkg::mret_word) begin
                        do_mret  = 1'b1;
                        pc_n     = mepc;
                        bubble_n = 2'd2;
                    end
                end
                default: ;                    // Unsupported, treated as nop
            endcase
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ir <= rv_pkg::nop_word;
        end else if (!hold_ir) begin
            // Words are stored big-endian
            ir <= {fetch_word[7:0], fetch_word[15:8], fetch_word[23:16], fetch_word[31:24]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pc               <= rv_pkg::reset_pc;
            bubble           <= 2'd2;     // Fill both fetch stages first
            ld_step          <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
            irq_ack          <= 1'b0;
        end else begin
            pc               <= pc_n;
            bubble           <= bubble_n;
            ld_step          <= ld_step_n;
            bus_read_enable  <= re_n;
            bus_write_enable <= we_n;
            irq_ack          <= take_trap;    // One pulse per trap
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (re_n || we_n) begin
            bus_address    <= addr_n;
            bus_write_data <= src2;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (wb_en) begin
            rf[rd] <= wb_data;
        end
        rf[0] <= '0;      // Last assignment wins
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

    // jalr target or mepc could break alignment
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) pc[1:0] == 2'b00);
endmodule

`default_nettype wire

// File: logic/rv_trap_csr.sv
`timescale 1ns/1ps
`default_nettype none

module rv_trap_csr (
    input  wire                     CLOCK_50,
    input  wire                     KEY0,
    input  wire                     take_trap,  // Interrupt accepted this cycle
    input  wire                     do_mret,
    input  wire [rv_pkg::xlen-1:0]  trap_pc,    // Instruction left unexecuted
    output logic                    mie,
    output logic [rv_pkg::xlen-1:0] mepc
);
    logic [rv_pkg::xlen-1:0] mstatus;
    logic [rv_pkg::xlen-1:0] mcause;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mstatus                          <= '0;
            mstatus[rv_pkg::mstatus_mie_bit] <= 1'b1;   // Interrupts on from reset
            mcause                           <= '0;
        end else if (take_trap) begin
            mstatus[rv_pkg::mstatus_mpie_bit] <= mstatus[rv_pkg::mstatus_mie_bit];
            mstatus[rv_pkg::mstatus_mie_bit]  <= 1'b0;  // No nesting
            mcause                            <= rv_pkg::mcause_ext_irq;
        end else if (do_mret) begin
            mstatus[rv_pkg::mstatus_mie_bit]  <= mstatus[rv_pkg::mstatus_mpie_bit];
            mstatus[rv_pkg::mstatus_mpie_bit] <= 1'b1;
        end
    end

    // Return address
    always_ff @(posedge CLOCK_50) begin
        if (take_trap) begin
            mepc <= trap_pc;
        end
    end

    assign mie = mstatus[rv_pkg::mstatus_mie_bit];

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) !(take_trap && do_mret));

    // mret only ever leaves a handler entered through a trap
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        do_mret |-> mcause == rv_pkg::mcause_ext_irq);
endmodule

`default_nettype wire

// File: logic/rv_imm_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_decode (
    input  wire  [31:0]                     ir,
    output logic [4:0]                      rd,
    output logic [4:0]                      rs1,
    output logic [4:0]                      rs2,
    output logic signed [rv_pkg::xlen-1:0]  imm_u,
    output logic signed [rv_pkg::xlen-1:0]  imm_i,
    output logic signed [rv_pkg::xlen-1:0]  imm_s,
    output logic signed [rv_pkg::xlen-1:0]  imm_b,
    output logic signed [rv_pkg::xlen-1:0]  imm_j
);
    assign rd  = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // lui, auipc
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};

    // addi, ld, jalr
    assign imm_i = {{52{ir[31]}}, ir[31:20]};

    // sd, split field
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};

    // beq, 13-bit even offset
    assign imm_b = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

    // jal, 21-bit even offset
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;
    localparam int xlen          = 64;   // Register width
    localparam int ram_words     = 1024; // 32-bit words in the block RAM
    localparam int ram_addr_bits = 10;

    // Memory map
    localparam logic [63:0] ram_base    = 64'h0000_0000_0000_0000;
    localparam logic [63:0] char_addr   = 64'h0000_0000_0000_2000; // Character output port
    localparam logic [63:0] reset_pc    = ram_base;
    localparam logic [63:0] trap_vector = 64'h0000_0000_0000_0100; // Fixed handler, no mtvec

    // Interrupt flag in bit 63, machine external interrupt code 11
    localparam logic [63:0] mcause_ext_irq = 64'h8000_0000_0000_000B;
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] funct3_ld_sd    = 3'd3; // Doubleword access
    localparam logic [2:0] funct3_beq_addi = 3'd0;

    localparam logic [31:0] mret_word = 32'h3020_0073;
    localparam logic [31:0] nop_word  = 32'h0000_0001; // Matches no opcode
endpackage

`default_nettype wire
